// ==== core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath word, also the instruction width
`define WORD_W 16

// General register file
`define REG_CNT 8
`define REG_AW 3

// Opcode 00001 with all other bits zero
`define NOP_INSTR 16'h0800

`endif

// ==== exe_bus_if.sv ====
`timescale 1ns/10ps

interface exe_bus_if;
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t     op1;       // First ALU operand
	word_t     op2;       // Second operand or shift amount
	alu_op_t   alu_op;
	logic      reg_write; // Qualifies dest for this cycle
	reg_addr_t dest;

	// Decode side owns the pipeline register
	modport stage_src (
		output op1, op2, alu_op, reg_write, dest
	);

	// Execute side only consumes
	modport stage_dst (
		input op1, op2, alu_op, reg_write, dest
	);

endinterface

// ==== exe_unit.sv ====
`timescale 1ns/10ps

module exe_unit (
	input  logic               clk,
	input  logic               reset,
	exe_bus_if.stage_dst       ex,
	output isa_pkg::word_t     alu_result,
	output logic               wb_en,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::word_t     wb_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic [3:0] shamt;

	assign shamt = ex.op2[3:0]; // Up to eight from decode

	////////////////////
	// ALU
	////////////////////
	// Also feeds the forwarding path back into decode
	always_comb begin
		case (ex.alu_op)
			ALU_ADD:  alu_result = ex.op1 + ex.op2;
			ALU_SUB:  alu_result = ex.op1 - ex.op2;
			ALU_AND:  alu_result = ex.op1 & ex.op2;
			ALU_OR:   alu_result = ex.op1 | ex.op2;
			ALU_SLL:  alu_result = ex.op1 << shamt;
			ALU_SRL:  alu_result = ex.op1 >> shamt;
			ALU_SRA:  alu_result = word_t'($signed(ex.op1) >>> shamt);
			default:  alu_result = ex.op1;  // Pass op1
		endcase
	end

	////////////////////
	// Write-back register
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_en <= 1'b0;
		end else begin
			wb_en <= ex.reg_write;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr <= ex.dest;     // Only meaningful with wb_en
		wb_data <= alu_result;
	end

endmodule

// ==== id_exe.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module id_exe (
	input  logic               clk,
	input  logic               reset,
	input  isa_pkg::word_t     instr,
	input  logic               hold,
	output isa_pkg::reg_addr_t rd_addr1,
	output isa_pkg::reg_addr_t rd_addr2,
	input  isa_pkg::word_t     rd_data1,
	input  isa_pkg::word_t     rd_data2,
	input  isa_pkg::word_t     alu_result,
	exe_bus_if.stage_src       ex
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t     cur_instr;
	opcode_t   opcode;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	word_t     imm8_sext;
	word_t     imm8_zext;
	word_t     imm4_sext;
	word_t     shamt;
	word_t     src_x;
	word_t     src_y;

	word_t     next_op1;
	word_t     next_op2;
	alu_op_t   next_alu_op;
	reg_addr_t next_dest;
	logic      next_wr;

	////////////////////
	// Field extraction
	////////////////////
	assign cur_instr = hold ? `NOP_INSTR : instr; // Hold turns the slot into a NOP
	assign opcode    = cur_instr[15:11];
	assign rx        = cur_instr[10:8];
	assign ry        = cur_instr[7:5];
	assign rz        = cur_instr[4:2];

	assign imm8_sext = {{(`WORD_W-8){cur_instr[7]}}, cur_instr[7:0]};
	assign imm8_zext = {{(`WORD_W-8){1'b0}}, cur_instr[7:0]};
	assign imm4_sext = {{(`WORD_W-4){cur_instr[3]}}, cur_instr[3:0]};
	// Shift field of zero encodes eight
	assign shamt = (cur_instr[4:2] == 3'd0) ? word_t'(8) : word_t'(cur_instr[4:2]);

	// Register file is always addressed by rx and ry
	assign rd_addr1 = rx;
	assign rd_addr2 = ry;

	// Item in execute is newer than anything in the register file
	assign src_x = (ex.reg_write && (ex.dest == rx)) ? alu_result : rd_data1;
	assign src_y = (ex.reg_write && (ex.dest == ry)) ? alu_result : rd_data2;

	////////////////////
	// Decode
	////////////////////
	always_comb begin
		next_op1    = '0;
		next_op2    = '0;
		next_alu_op = ALU_PASS_A;
		next_dest   = rx;
		next_wr     = 1'b0;
		case (opcode)
			OP_ADDIU: begin
				next_op1    = src_x;
				next_op2    = imm8_sext;
				next_alu_op = ALU_ADD;
				next_wr     = 1'b1;
			end
			OP_ADDIU3: begin
				next_op1    = src_x;
				next_op2    = imm4_sext;
				next_alu_op = ALU_ADD;
				next_dest   = ry; // Result goes to ry here
				next_wr     = 1'b1;
			end
			OP_ADDSUB: begin
				next_op1  = src_x;
				next_op2  = src_y;
				next_dest = rz;
				if (cur_instr[1:0] == FN_ADDU) begin
					next_alu_op = ALU_ADD;
					next_wr     = 1'b1;
				end else if (cur_instr[1:0] == FN_SUBU) begin
					next_alu_op = ALU_SUB;
					next_wr     = 1'b1;
				end
			end
			OP_LOGIC: begin
				next_op1 = src_x;
				next_op2 = src_y;
				if (cur_instr[4:0] == FN_AND) begin
					next_alu_op = ALU_AND;
					next_wr     = 1'b1;
				end else if (cur_instr[4:0] == FN_OR) begin
					next_alu_op = ALU_OR;
					next_wr     = 1'b1;
				end
			end
			OP_SHIFT: begin
				next_op1 = src_y;  // Shifted value is ry
				next_op2 = shamt;
				next_wr  = (cur_instr[1:0] != 2'b01); // 01 is not a shift
				case (cur_instr[1:0])
					FN_SLL:  next_alu_op = ALU_SLL;
					FN_SRL:  next_alu_op = ALU_SRL;
					FN_SRA:  next_alu_op = ALU_SRA;
					default: next_alu_op = ALU_PASS_A;
				endcase
			end
			OP_LI: begin
				next_op1 = imm8_zext;
				next_wr  = 1'b1;
			end
			OP_MOVE: begin
				next_op1 = src_y;
				next_wr  = 1'b1;
			end
			OP_NOP: begin
				next_wr = 1'b0;  // Bubble
			end
			default: begin
				next_wr = 1'b0;  // Unknown encodings behave as NOP
			end
		endcase
	end

	////////////////////
	// Decode to execute register
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			ex.op1       <= '0;
			ex.op2       <= '0;
			ex.alu_op    <= ALU_PASS_A;
			ex.dest      <= '0;
			ex.reg_write <= 1'b0;
		end else begin
			ex.op1       <= next_op1;
			ex.op2       <= next_op2;
			ex.alu_op    <= next_alu_op;
			ex.dest      <= next_dest;
			ex.reg_write <= next_wr;
		end
	end

endmodule

// ==== isa_pkg.sv ====
`include "core_params.svh"

package isa_pkg;

	typedef logic [`WORD_W-1:0] word_t;   // Data or instruction word
	typedef logic [`REG_AW-1:0] reg_addr_t; // Register number
	typedef logic [4:0] opcode_t;          // Major opcode, bits 15:11
	typedef logic [1:0] funct2_t;          // Bits 1:0
	typedef logic [4:0] funct5_t;          // Bits 4:0

	////////////////////
	// Major opcodes
	////////////////////
	localparam opcode_t OP_NOP    = 5'b00001;
	localparam opcode_t OP_SHIFT  = 5'b00110; // SLL, SRL, SRA
	localparam opcode_t OP_ADDIU3 = 5'b01000;
	localparam opcode_t OP_ADDIU  = 5'b01001;
	localparam opcode_t OP_LI     = 5'b01101;
	localparam opcode_t OP_MOVE   = 5'b01111;
	localparam opcode_t OP_ADDSUB = 5'b11100; // ADDU, SUBU
	localparam opcode_t OP_LOGIC  = 5'b11101; // AND, OR and friends

	////////////////////
	// Function codes
	////////////////////
	localparam funct2_t FN_ADDU = 2'b01;
	localparam funct2_t FN_SUBU = 2'b11;

	localparam funct5_t FN_AND = 5'b01100;
	localparam funct5_t FN_OR  = 5'b01101;

	// Shift group, amount in bits 4:2
	localparam funct2_t FN_SLL = 2'b00;
	localparam funct2_t FN_SRL = 2'b10;
	localparam funct2_t FN_SRA = 2'b11;

endpackage

// ==== mips16_core.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
exe_bus_if.sv
reg_file.sv
id_exe.sv
exe_unit.sv
mips16_core.sv
tb_mips16_core.sv

// ==== mips16_core.sv ====
`timescale 1ns/10ps

module mips16_core (
	input  logic               clk,
	input  logic               reset,
	input  isa_pkg::word_t     instr,
	input  logic               hold,
	output logic               wb_en,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::word_t     wb_data
);
	import isa_pkg::*;

	reg_addr_t rd_addr1;
	reg_addr_t rd_addr2;
	word_t     rd_data1;
	word_t     rd_data2;
	word_t     alu_result; // Execute result, forwarded to decode

	exe_bus_if u_ex_bus ();

	reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.wb_en    (wb_en),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

	id_exe u_id_exe (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.hold       (hold),
		.rd_addr1   (rd_addr1),
		.rd_addr2   (rd_addr2),
		.rd_data1   (rd_data1),
		.rd_data2   (rd_data2),
		.alu_result (alu_result),
		.ex         (u_ex_bus.stage_src)
	);

	exe_unit u_exe_unit (
		.clk        (clk),
		.reset      (reset),
		.ex         (u_ex_bus.stage_dst),
		.alu_result (alu_result),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data)
	);

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

	////////////////////
	// ALU operations
	////////////////////
	// Chosen in decode, carried to execute with the operands.
	// ALU_PASS_A forwards op1 unchanged, used by LI, MOVE and bubbles.
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_SLL    = 3'd4,
		ALU_SRL    = 3'd5,
		ALU_SRA    = 3'd6,
		ALU_PASS_A = 3'd7
	} alu_op_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module reg_file (
	input  logic              clk,
	input  logic              reset,
	input  isa_pkg::reg_addr_t rd_addr1,
	input  isa_pkg::reg_addr_t rd_addr2,
	output isa_pkg::word_t     rd_data1,
	output isa_pkg::word_t     rd_data2,
	input  logic              wb_en,
	input  isa_pkg::reg_addr_t wb_addr,
	input  isa_pkg::word_t     wb_data
);
	import isa_pkg::*;

	word_t regs [`REG_CNT];

	////////////////////
	// Write port
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	////////////////////
	// Read ports
	////////////////////
	// A same-cycle write shows through, so an instruction two behind
	// the writer sees the new value without waiting for the edge
	always_comb begin
		rd_data1 = regs[rd_addr1];
		rd_data2 = regs[rd_addr2];
		if (wb_en && (wb_addr == rd_addr1))
			rd_data1 = wb_data;  // Write-through
		if (wb_en && (wb_addr == rd_addr2))
			rd_data2 = wb_data;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mips16_core \
	-f mips16_core.f -o tb_mips16_core > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mips16_core > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi
exit 0

// ==== tb_mips16_core.sv ====
`timescale 1ns/10ps

module tb_mips16_core;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	localparam int N_DIRECTED   = 60;  // Upper bound of directed issues
	localparam int N_RANDOM     = 400;

	localparam logic [4:0] OP_SHIFT  = 5'b00110;
	localparam logic [4:0] OP_ADDIU3 = 5'b01000;
	localparam logic [4:0] OP_ADDIU  = 5'b01001;
	localparam logic [4:0] OP_LI     = 5'b01101;
	localparam logic [4:0] OP_MOVE   = 5'b01111;
	localparam logic [4:0] OP_RRR    = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] OP_RR     = 5'b11101; // AND, OR
	localparam logic [15:0] NOP_WORD = 16'h0800;

	logic        clk;
	logic        reset;
	logic [15:0] instr;
	logic        hold;
	logic        wb_en;
	logic [2:0]  wb_addr;
	logic [15:0] wb_data;

	logic [15:0] model_regs [8];
	logic [31:0] lfsr_state;
	logic        exp_en;   // Expectation for the word on instr
	logic [2:0]  exp_addr;
	logic [15:0] exp_data;
	logic        en_d1;
	logic        en_d2;
	logic [2:0]  addr_d1;
	logic [2:0]  addr_d2;
	logic [15:0] data_d1;
	logic [15:0] data_d2;

	mips16_core u_dut (
		.clk     (clk),
		.reset   (reset),
		.instr   (instr),
		.hold    (hold),
		.wb_en   (wb_en),
		.wb_addr (wb_addr),
		.wb_data (wb_data)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]}; // One step per bit
		end
		return v;
	endfunction

	function automatic logic [15:0] make_i8(input logic [4:0] op, input logic [2:0] rx,
			input logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic logic [15:0] make_rr(input logic [4:0] op, input logic [2:0] rx,
			input logic [2:0] ry, input logic [4:0] low);
		return {op, rx, ry, low};
	endfunction

	////////////////////
	// Reference model
	////////////////////
	task automatic predict(input logic [15:0] w, input logic h, output logic en,
			output logic [2:0] addr, output logic [15:0] data);
		logic [15:0] vx;
		logic [15:0] vy;
		logic [3:0]  sa;
		vx   = model_regs[w[10:8]];
		vy   = model_regs[w[7:5]];
		sa   = (w[4:2] == 3'd0) ? 4'd8 : {1'b0, w[4:2]}; // Zero means eight
		en   = 1'b1;
		addr = w[10:8];
		data = '0;
		case (w[15:11])
			OP_ADDIU: data = vx + {{8{w[7]}}, w[7:0]};
			OP_ADDIU3: begin
				addr = w[7:5];
				data = vx + {{12{w[3]}}, w[3:0]};
			end
			OP_LI:   data = {8'h00, w[7:0]};
			OP_MOVE: data = vy;
			OP_RRR: begin
				addr = w[4:2];
				case (w[1:0])
					2'b01:   data = vx + vy;
					2'b11:   data = vx - vy;
					default: en = 1'b0;
				endcase
			end
			OP_RR: begin
				case (w[4:0])
					5'b01100: data = vx & vy;
					5'b01101: data = vx | vy;
					default:  en = 1'b0;
				endcase
			end
			OP_SHIFT: begin
				case (w[1:0])
					2'b00:   data = vy << sa;
					2'b10:   data = vy >> sa;
					2'b11:   data = 16'($signed(vy) >>> sa);
					default: en = 1'b0;
				endcase
			end
			default: en = 1'b0; // NOP and unknown words
		endcase
		if (h)
			en = 1'b0;  // Held slot is a bubble
		if (en)
			model_regs[addr] = data;
	endtask

	task automatic issue(input logic [15:0] w, input logic h);
		logic        en;
		logic [2:0]  addr;
		logic [15:0] data;
		predict(w, h, en, addr, data);
		@(posedge clk);
		instr    <= w;
		hold     <= h;
		exp_en   <= en;
		exp_addr <= addr;
		exp_data <= data;
	endtask

	function automatic logic [15:0] random_instr();
		logic [2:0]  rx;
		logic [2:0]  ry;
		logic [15:0] w;
		rx = 3'(rand_bits(3));
		ry = 3'(rand_bits(3));
		case (3'(rand_bits(3)))
			3'd0:    w = make_i8(OP_ADDIU, rx, 8'(rand_bits(8)));
			3'd1:    w = make_rr(OP_ADDIU3, rx, ry, 5'(rand_bits(5)));
			3'd2:    w = make_rr(OP_RRR, rx, ry, 5'(rand_bits(5)));
			3'd3:    w = make_rr(OP_RR, rx, ry, {4'b0110, 1'(rand_bits(1))});
			3'd4:    w = make_rr(OP_SHIFT, rx, ry, 5'(rand_bits(5)));
			3'd5:    w = make_i8(OP_LI, rx, 8'(rand_bits(8)));
			3'd6:    w = make_rr(OP_MOVE, rx, ry, 5'd0);
			default: w = 16'(rand_bits(16)); // Mostly unknown encodings
		endcase
		return w;
	endfunction

	////////////////////
	// Checking
	////////////////////
	always @(posedge clk) begin
		if (reset) begin
			en_d1 <= 1'b0;
			en_d2 <= 1'b0;
		end else begin
			en_d1   <= exp_en;
			en_d2   <= en_d1;
			addr_d1 <= exp_addr;
			addr_d2 <= addr_d1;
			data_d1 <= exp_data;
			data_d2 <= data_d1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) wb_en == en_d2)
		else fail_run($sformatf("** Error at %0t: wb_en expected %0b, got %0b",
			$time, $sampled(en_d2), $sampled(wb_en)));
	assert property (@(posedge clk) disable iff (reset) en_d2 |-> wb_addr == addr_d2)
		else fail_run($sformatf("** Error at %0t: wb_addr expected %0d, got %0d",
			$time, $sampled(addr_d2), $sampled(wb_addr)));
	assert property (@(posedge clk) disable iff (reset) en_d2 |-> wb_data == data_d2)
		else fail_run($sformatf("** Error at %0t: wb_data expected %h, got %h",
			$time, $sampled(data_d2), $sampled(wb_data)));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((N_DIRECTED + N_RANDOM + RESET_CYCLES + 20) * CLK_PERIOD);
		fail_run("Watchdog expired before the instruction stream finished");
	end

	////////////////////
	// Stimulus
	////////////////////
	initial begin
		logic [15:0] w;
		logic        h;
		reset      = 1'b1;
		instr      = NOP_WORD;
		hold       = 1'b0;
		exp_en     = 1'b0;
		exp_addr   = '0;
		exp_data   = '0;
		lfsr_state = 32'h9a650599;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		repeat (4) issue(NOP_WORD, 1'b0); // Quiet after reset
		for (int r = 0; r < 8; r++)
			issue(make_rr(OP_MOVE, 3'(r), 3'(r), 5'd0), 1'b0);

		issue(make_i8(OP_LI, 3'd1, 8'h7f), 1'b0);
		issue(make_i8(OP_LI, 3'd2, 8'hff), 1'b0);                 // Zero extended
		issue(make_i8(OP_ADDIU, 3'd1, 8'hff), 1'b0);              // Minus one
		issue(make_rr(OP_ADDIU3, 3'd2, 3'd3, 5'h08), 1'b0);       // r3 = r2 - 8
		issue(make_rr(OP_RRR, 3'd1, 3'd2, {3'd4, 2'b01}), 1'b0);
		issue(make_rr(OP_RRR, 3'd1, 3'd2, {3'd5, 2'b11}), 1'b0);  // Goes negative
		issue(make_rr(OP_RRR, 3'd5, 3'd5, {3'd7, 2'b01}), 1'b0);  // Carry out dropped
		issue(make_i8(OP_ADDIU, 3'd5, 8'h80), 1'b0);

		issue(make_rr(OP_RR, 3'd5, 3'd2, 5'b01100), 1'b0);
		issue(make_rr(OP_RR, 3'd4, 3'd3, 5'b01101), 1'b0);
		issue(make_rr(OP_SHIFT, 3'd1, 3'd2, {3'd0, 2'b00}), 1'b0); // By eight
		issue(make_rr(OP_SHIFT, 3'd3, 3'd1, {3'd3, 2'b10}), 1'b0);
		issue(make_rr(OP_SHIFT, 3'd4, 3'd7, {3'd0, 2'b11}), 1'b0);
		issue(make_rr(OP_SHIFT, 3'd6, 3'd7, {3'd5, 2'b11}), 1'b0);
		issue(make_rr(OP_SHIFT, 3'd6, 3'd1, {3'd0, 2'b10}), 1'b0);

		issue(make_i8(OP_LI, 3'd1, 8'h05), 1'b0);
		issue(make_i8(OP_ADDIU, 3'd1, 8'h03), 1'b0);              // Distance 1
		issue(make_rr(OP_RRR, 3'd1, 3'd1, {3'd2, 2'b01}), 1'b0);
		issue(make_i8(OP_LI, 3'd3, 8'h09), 1'b0);
		issue(NOP_WORD, 1'b0);
		issue(make_i8(OP_ADDIU, 3'd3, 8'h01), 1'b0);              // Distance 2
		issue(make_i8(OP_LI, 3'd4, 8'h11), 1'b0);
		issue(make_rr(OP_MOVE, 3'd5, 3'd1, 5'd0), 1'b0);
		issue(make_rr(OP_RRR, 3'd4, 3'd4, {3'd6, 2'b11}), 1'b0);

		issue(make_i8(OP_LI, 3'd1, 8'h42), 1'b1);                 // Dropped
		issue(make_rr(OP_MOVE, 3'd2, 3'd1, 5'd0), 1'b0);
		issue(make_i8(OP_ADDIU, 3'd2, 8'h01), 1'b1);
		issue(NOP_WORD, 1'b0);
		issue(make_rr(OP_MOVE, 3'd0, 3'd2, 5'd0), 1'b0);

		for (int i = 0; i < N_RANDOM; i++) begin
			w = random_instr();
			h = (rand_bits(3) == 32'd0);
			issue(w, h);
		end

		repeat (3) issue(NOP_WORD, 1'b0); // Drain the pipeline
		@(posedge clk);
		$display(">>> PASS");
		$finish;
	end

endmodule
